/* decode_params.svh */
// decode stage widths, instruction field positions and the opcode table
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// widths
`define INST_W          32
`define OPCODE_W        11
`define REG_ADDR_W      7

// field start positions, word bit 0 is the msb
`define RT_POS          25
`define RA_POS          18
`define RB_POS          11
`define RC_POS          25
`define RRR_RT_POS      4
`define IMM7_POS        11
`define IMM10_POS       8
`define IMM16_POS       9
`define IMM18_POS       7

// fillers
`define OP_NOP          11'b0100_0000_001
`define OP_LNOP         11'b0100_0000_010

// even pipe
`define OP_MPYA         4'b1100
`define OP_ILA          7'b0100_001
`define OP_AI           8'b0001_1100
`define OP_SFI          8'b0000_1100
`define OP_IL           9'b0100_0000_1
`define OP_A            11'b0001_1000_000
`define OP_SF           11'b0000_1000_000
`define OP_XSWD         11'b0101_0110_110
`define OP_SHLI         11'b0000_1111_011

// odd pipe
`define OP_LQA          9'b0011_0000_1
`define OP_STQA         9'b0011_0010_0
`define OP_BI           11'b0011_0101_000
`define OP_ROTQBYI      11'b0011_1111_100
`define OP_ROTQBY       11'b0011_1011_100

`endif

/* decode_pkg.sv */
// shared types for the dual-issue decode stage: pipes, issue slots and fetch pairs
`include "decode_params.svh"

package decode_pkg;

    // opcode prefixes shorter than 11 bits are right-justified
    typedef logic [`OPCODE_W-1:0]   opcode_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic {
        PIPE_EVEN = 1'b0,
        PIPE_ODD  = 1'b1
    } pipe_t;

    // one issue slot, fields the format does not use stay zero
    typedef struct packed {
        opcode_t            opcode;
        reg_addr_t          rt;
        reg_addr_t          ra;
        reg_addr_t          rb;
        reg_addr_t          rc;
        logic signed [6:0]  imm7;
        logic signed [9:0]  imm10;
        logic signed [15:0] imm16;
        logic signed [17:0] imm18;
    } slot_t;

    // decoder result for one word
    typedef struct packed {
        pipe_t pipe;
        logic  nop;
        slot_t slot;
    } decoded_t;

    // pair from fetch, first word in the upper half
    typedef struct packed {
        logic [0:`INST_W-1] first;
        logic [0:`INST_W-1] second;
    } inst_pair_t;

    // filler for a pipe with nothing to issue
    function automatic slot_t nop_slot(input pipe_t pipe);
        slot_t s;
        s        = '0;
        s.opcode = (pipe == PIPE_EVEN) ? `OP_NOP : `OP_LNOP;
        return s;
    endfunction

endpackage

/* inst_decoder.sv */
// instruction decoder: classifies one word by opcode prefix and extracts its fields
`include "decode_params.svh"

module inst_decoder (
    input  logic [0:`INST_W-1]   inst,
    output decode_pkg::decoded_t decoded
);

    // opcode prefixes of every length in the table
    logic [3:0]  pre4;
    logic [6:0]  pre7;
    logic [7:0]  pre8;
    logic [8:0]  pre9;
    logic [10:0] pre11;

    // raw fields at their fixed positions
    decode_pkg::reg_addr_t field_rt;
    decode_pkg::reg_addr_t field_ra;
    decode_pkg::reg_addr_t field_rb;
    decode_pkg::reg_addr_t field_rc;
    decode_pkg::reg_addr_t field_rrr_rt;
    logic signed [6:0]     field_imm7;
    logic signed [9:0]     field_imm10;
    logic signed [15:0]    field_imm16;
    logic signed [17:0]    field_imm18;

    assign pre4  = inst[0 +: 4];
    assign pre7  = inst[0 +: 7];
    assign pre8  = inst[0 +: 8];
    assign pre9  = inst[0 +: 9];
    assign pre11 = inst[0 +: `OPCODE_W];

    assign field_rt     = inst[`RT_POS +: `REG_ADDR_W];
    assign field_ra     = inst[`RA_POS +: `REG_ADDR_W];
    assign field_rb     = inst[`RB_POS +: `REG_ADDR_W];
    assign field_rc     = inst[`RC_POS +: `REG_ADDR_W];
    assign field_rrr_rt = inst[`RRR_RT_POS +: `REG_ADDR_W];
    assign field_imm7   = inst[`IMM7_POS +: 7];
    assign field_imm10  = inst[`IMM10_POS +: 10];
    assign field_imm16  = inst[`IMM16_POS +: 16];
    assign field_imm18  = inst[`IMM18_POS +: 18];

    // shorter prefixes first, even before odd
    always_comb begin
        decoded      = '0;
        decoded.pipe = decode_pkg::PIPE_EVEN;
        // ----------------------------------------
        // even pipe
        if (pre4 == `OP_MPYA) begin
            // rrr, rt sits in front of the sources
            decoded.slot.opcode = decode_pkg::opcode_t'(pre4);
            decoded.slot.rt     = field_rrr_rt;
            decoded.slot.rb     = field_rb;
            decoded.slot.ra     = field_ra;
            decoded.slot.rc     = field_rc;
        end else if (pre7 == `OP_ILA) begin
            decoded.slot.opcode = decode_pkg::opcode_t'(pre7);
            decoded.slot.imm18  = field_imm18;
            decoded.slot.rt     = field_rt;
        end else if (pre8 == `OP_AI || pre8 == `OP_SFI) begin
            decoded.slot.opcode = decode_pkg::opcode_t'(pre8);
            decoded.slot.imm10  = field_imm10;
            decoded.slot.ra     = field_ra;
            decoded.slot.rt     = field_rt;
        end else if (pre9 == `OP_IL) begin
            decoded.slot.opcode = decode_pkg::opcode_t'(pre9);
            decoded.slot.imm16  = field_imm16;
            decoded.slot.rt     = field_rt;
        end else if (pre11 == `OP_A || pre11 == `OP_SF) begin
            decoded.slot.opcode = pre11;
            decoded.slot.rb     = field_rb;
            decoded.slot.ra     = field_ra;
            decoded.slot.rt     = field_rt;
        end else if (pre11 == `OP_XSWD) begin
            // single source
            decoded.slot.opcode = pre11;
            decoded.slot.ra     = field_ra;
            decoded.slot.rt     = field_rt;
        end else if (pre11 == `OP_SHLI) begin
            decoded.slot.opcode = pre11;
            decoded.slot.imm7   = field_imm7;
            decoded.slot.ra     = field_ra;
            decoded.slot.rt     = field_rt;
        // ----------------------------------------
        // odd pipe
        end else if (pre9 == `OP_LQA) begin
            decoded.pipe        = decode_pkg::PIPE_ODD;
            decoded.slot.opcode = decode_pkg::opcode_t'(pre9);
            decoded.slot.imm16  = field_imm16;
            decoded.slot.rt     = field_rt;
        end else if (pre9 == `OP_STQA) begin
            // no target register
            decoded.pipe        = decode_pkg::PIPE_ODD;
            decoded.slot.opcode = decode_pkg::opcode_t'(pre9);
            decoded.slot.imm16  = field_imm16;
        end else if (pre11 == `OP_BI) begin
            decoded.pipe        = decode_pkg::PIPE_ODD;
            decoded.slot.opcode = pre11;
            decoded.slot.ra     = field_ra;
        end else if (pre11 == `OP_ROTQBYI) begin
            decoded.pipe        = decode_pkg::PIPE_ODD;
            decoded.slot.opcode = pre11;
            decoded.slot.imm7   = field_imm7;
            decoded.slot.ra     = field_ra;
            decoded.slot.rt     = field_rt;
        end else if (pre11 == `OP_ROTQBY) begin
            decoded.pipe        = decode_pkg::PIPE_ODD;
            decoded.slot.opcode = pre11;
            decoded.slot.rb     = field_rb;
            decoded.slot.ra     = field_ra;
            decoded.slot.rt     = field_rt;
        end else if (pre11 == `OP_LNOP) begin
            decoded.pipe = decode_pkg::PIPE_ODD;
            decoded.nop  = 1'b1;
            decoded.slot = decode_pkg::nop_slot(decode_pkg::PIPE_ODD);
        end else begin
            // even nop, and anything not in the table
            decoded.nop  = 1'b1;
            decoded.slot = decode_pkg::nop_slot(decode_pkg::PIPE_EVEN);
        end
    end

endmodule

/* issue_router.sv */
// issue router that steers a decoded pair to the pipes and splits same-pipe pairs
module issue_router (
    input  logic                 clk,
    input  logic                 reset,
    input  decode_pkg::decoded_t first,
    input  decode_pkg::decoded_t second,
    input  logic                 dependency_stall,
    output decode_pkg::slot_t    even_slot,
    output decode_pkg::slot_t    odd_slot,
    output logic                 decode_stall
);

    // set while the second half of a split pair is pending
    logic              split;
    logic              same_pipe;

    logic              take_first_even;
    logic              take_first_odd;
    logic              take_second_even;
    logic              take_second_odd;

    decode_pkg::slot_t even_next;
    decode_pkg::slot_t odd_next;

    // word is a real instruction for pipe p
    function automatic logic wants(
        input decode_pkg::decoded_t d,
        input decode_pkg::pipe_t    p
    );
        return (d.pipe == p) && !d.nop;
    endfunction

    // ----------------------------------------
    // hazard detect
    // ----------------------------------------

    // both words need the same pipe and neither is a nop
    assign same_pipe = (first.pipe == second.pipe) && !first.nop && !second.nop;

    // first word goes out unless the split already sent it
    assign take_first_even = !split && wants(first, decode_pkg::PIPE_EVEN);
    assign take_first_odd  = !split && wants(first, decode_pkg::PIPE_ODD);

    // second word waits one cycle when it collides with the first
    assign take_second_even = (split || !same_pipe) && wants(second, decode_pkg::PIPE_EVEN);
    assign take_second_odd  = (split || !same_pipe) && wants(second, decode_pkg::PIPE_ODD);

    // ----------------------------------------
    // slot select
    // ----------------------------------------

    always_comb begin
        if (take_first_even) begin
            even_next = first.slot;
        end else if (take_second_even) begin
            even_next = second.slot;
        end else begin
            even_next = decode_pkg::nop_slot(decode_pkg::PIPE_EVEN);
        end
    end

    always_comb begin
        if (take_first_odd) begin
            odd_next = first.slot;
        end else if (take_second_odd) begin
            odd_next = second.slot;
        end else begin
            odd_next = decode_pkg::nop_slot(decode_pkg::PIPE_ODD);
        end
    end

    // fetch holds the pair on the first half of a split or on a downstream stall
    assign decode_stall = reset && (dependency_stall || (same_pipe && !split));

    // ----------------------------------------
    // issue registers
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!reset) begin
            split     <= 1'b0;
            even_slot <= decode_pkg::nop_slot(decode_pkg::PIPE_EVEN);
            odd_slot  <= decode_pkg::nop_slot(decode_pkg::PIPE_ODD);
        end else if (!dependency_stall) begin
            split     <= same_pipe && !split;
            even_slot <= even_next;
            odd_slot  <= odd_next;
        end
    end

    // pair is held by fetch for the second half of a split
    split_pair_held: assert property (
        @(posedge clk) disable iff (!reset)
        split |-> (first.pipe == second.pipe) && !first.nop && !second.nop
    );

endmodule

/* dual_decode.sv */
// dual-issue decode stage top: two word decoders feeding the issue router
module dual_decode (
    input  logic                   clk,
    input  logic                   reset,
    input  decode_pkg::inst_pair_t inst_pair,
    input  logic                   dependency_stall,
    output decode_pkg::slot_t      even_slot,
    output decode_pkg::slot_t      odd_slot,
    output logic                   decode_stall
);

    decode_pkg::decoded_t first_decoded;
    decode_pkg::decoded_t second_decoded;

    inst_decoder i_decode_first (
        .inst    (inst_pair.first),
        .decoded (first_decoded)
    );

    inst_decoder i_decode_second (
        .inst    (inst_pair.second),
        .decoded (second_decoded)
    );

    issue_router i_issue_router (
        .clk              (clk),
        .reset            (reset),
        .first            (first_decoded),
        .second           (second_decoded),
        .dependency_stall (dependency_stall),
        .even_slot        (even_slot),
        .odd_slot         (odd_slot),
        .decode_stall     (decode_stall)
    );

endmodule

/* tb_decode_tasks.svh */
// decode stage testbench helpers: reference model, value check and directed tests

// opcode of each format, 0 to 8 even, 9 to 13 odd
function automatic logic [10:0] opcode_of(input int k);
    case (k)
        0: return 11'(`OP_MPYA);
        1: return 11'(`OP_ILA);
        2: return 11'(`OP_AI);
        3: return 11'(`OP_SFI);
        4: return 11'(`OP_IL);
        5: return `OP_A;
        6: return `OP_SF;
        7: return `OP_XSWD;
        8: return `OP_SHLI;
        9: return 11'(`OP_LQA);
        10: return 11'(`OP_STQA);
        11: return `OP_BI;
        12: return `OP_ROTQBYI;
        default: return `OP_ROTQBY;
    endcase
endfunction

function automatic int prefix_len(input int k);
    case (k)
        0: return 4;
        1: return 7;
        2, 3: return 8;
        4, 9, 10: return 9;
        default: return 11;
    endcase
endfunction

// random fields with the format's opcode prefix on top
function automatic logic [0:31] make_word(input int k, input logic [31:0] fields);
    logic [31:0] mask;
    logic [31:0] aligned;
    mask    = ~(32'hffff_ffff >> prefix_len(k));
    aligned = {opcode_of(k), 21'b0} << (11 - prefix_len(k));
    return (fields & ~mask) | (aligned & mask);
endfunction

// slot a word of format k must produce
function automatic decode_pkg::slot_t expected_slot(input int k, input logic [0:31] w);
    decode_pkg::slot_t s;
    s        = '0;
    s.opcode = opcode_of(k);
    if (k == 0) begin
        s.rt = w[`RRR_RT_POS +: `REG_ADDR_W];
        s.rc = w[`RC_POS +: `REG_ADDR_W];
    end else if (k != 10 && k != 11) begin
        s.rt = w[`RT_POS +: `REG_ADDR_W];
    end
    if (!(k inside {1, 4, 9, 10})) begin
        s.ra = w[`RA_POS +: `REG_ADDR_W];
    end
    if (k inside {0, 5, 6, 13}) begin
        s.rb = w[`RB_POS +: `REG_ADDR_W];
    end
    if (k inside {8, 12}) begin
        s.imm7 = w[`IMM7_POS +: 7];
    end
    if (k inside {2, 3}) begin
        s.imm10 = w[`IMM10_POS +: 10];
    end
    if (k inside {4, 9, 10}) begin
        s.imm16 = w[`IMM16_POS +: 16];
    end
    if (k == 1) begin
        s.imm18 = w[`IMM18_POS +: 18];
    end
    return s;
endfunction

function automatic decode_pkg::slot_t filler(input logic odd);
    decode_pkg::slot_t s;
    s        = '0;
    s.opcode = odd ? `OP_LNOP : `OP_NOP;
    return s;
endfunction

task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                           input string what);
    if (actual !== expected) begin
        $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        error_count++;
    end
endtask

task automatic compare_outputs(input decode_pkg::slot_t even_exp,
                               input decode_pkg::slot_t odd_exp, input logic stall_exp);
    check_equal(128'(even_slot), 128'(even_exp), "even slot");
    check_equal(128'(odd_slot), 128'(odd_exp), "odd slot");
    check_equal(128'(decode_stall), 128'(stall_exp), "decode_stall");
endtask

task automatic begin_test();
    errors_at_start = error_count;
endtask

task automatic report_test(input string name);
    if (error_count == errors_at_start) begin
        tests_passed++;
        $display("test %s: passed", name);
    end else begin
        tests_failed++;
        $display("test %s: failed with %0d mismatches", name, error_count - errors_at_start);
    end
endtask

// ----------------------------------------
// fetch side
// ----------------------------------------

task automatic present(input logic [0:31] w1, input logic [0:31] w2);
    @(posedge clk);
    inst_pair <= {w1, w2};
    @(negedge clk);
endtask

// pair consumed, fetch moves on to an idle pair
task automatic advance();
    @(posedge clk);
    inst_pair <= {nop_word, lnop_word};
    @(negedge clk);
endtask

task automatic hold_and_compare(input int n, input decode_pkg::slot_t even_exp,
                                input decode_pkg::slot_t odd_exp, input logic stall_exp);
    repeat (n) begin
        @(posedge clk);
        @(negedge clk);
        compare_outputs(even_exp, odd_exp, stall_exp);
    end
endtask

task automatic wait_for_accept(input int limit);
    int n;
    n = 0;
    while (decode_stall && n < limit) begin
        @(posedge clk);
        @(negedge clk);
        n++;
    end
    if (decode_stall) begin
        $display("fetch pair still stalled after %0d cycles at %0t ns", limit, $time);
        error_count++;
    end
endtask

task automatic single_issue(input logic [0:31] w1, input logic [0:31] w2,
                            input decode_pkg::slot_t even_exp, input decode_pkg::slot_t odd_exp);
    present(w1, w2);
    check_equal(128'(decode_stall), 128'(1'b0), "decode_stall on a one-cycle pair");
    advance();
    compare_outputs(even_exp, odd_exp, 1'b0);
endtask

task automatic cross_pipe_pair(input int k1, input int k2);
    logic [0:31] w1;
    logic [0:31] w2;
    w1 = make_word(k1, $random(seed));
    w2 = make_word(k2, $random(seed));
    if (k1 >= 9) begin
        single_issue(w1, w2, expected_slot(k2, w2), expected_slot(k1, w1));
    end else begin
        single_issue(w1, w2, expected_slot(k1, w1), expected_slot(k2, w2));
    end
endtask

// both words on one pipe, issued over two cycles
task automatic same_pipe_pair(input int k1, input int k2);
    logic [0:31]       w1;
    logic [0:31]       w2;
    logic              odd;
    decode_pkg::slot_t other;
    w1    = make_word(k1, $random(seed));
    w2    = make_word(k2, $random(seed));
    odd   = (k1 >= 9);
    other = filler(!odd);
    present(w1, w2);
    check_equal(128'(decode_stall), 128'(1'b1), "decode_stall on a same-pipe pair");
    hold_and_compare(1, odd ? other : expected_slot(k1, w1),
                     odd ? expected_slot(k1, w1) : other, 1'b0);
    advance();
    compare_outputs(odd ? other : expected_slot(k2, w2),
                    odd ? expected_slot(k2, w2) : other, 1'b0);
endtask

// ----------------------------------------
// directed tests
// ----------------------------------------

task automatic reset_values();
    begin_test();
    @(negedge clk);
    check_equal(128'(decode_stall), 128'(1'b0), "decode_stall in reset");
    @(posedge clk);
    reset     <= 1'b1;
    inst_pair <= {nop_word, lnop_word};
    @(negedge clk);
    compare_outputs(filler(1'b0), filler(1'b1), 1'b0);
    report_test("reset values");
endtask

task automatic even_formats();
    begin_test();
    for (int k = 0; k < 9; k++) begin
        cross_pipe_pair(k, 13);
        cross_pipe_pair(13, k);
    end
    report_test("even formats");
endtask

task automatic odd_formats();
    begin_test();
    for (int k = 9; k < 14; k++) begin
        cross_pipe_pair(k, 5);
        cross_pipe_pair(5, k);
    end
    report_test("odd formats");
endtask

task automatic split_pairs();
    begin_test();
    same_pipe_pair(1, 5);
    same_pipe_pair(0, 7);
    same_pipe_pair(9, 11);
    same_pipe_pair(13, 12);
    report_test("split pairs");
endtask

task automatic nop_pairs();
    logic [0:31] add_word;
    logic [0:31] rot_word;
    logic [0:31] bad_word;
    begin_test();
    add_word = make_word(5, $random(seed));
    rot_word = make_word(13, $random(seed));
    // all-ones prefix is not in the opcode table
    bad_word = 32'($random(seed)) | 32'hffe0_0000;
    single_issue(nop_word, add_word, expected_slot(5, add_word), filler(1'b1));
    single_issue(rot_word, lnop_word, filler(1'b0), expected_slot(13, rot_word));
    single_issue(bad_word, rot_word, filler(1'b0), expected_slot(13, rot_word));
    single_issue(add_word, bad_word, expected_slot(5, add_word), filler(1'b1));
    single_issue(nop_word, nop_word, filler(1'b0), filler(1'b1));
    report_test("nop pairs");
endtask

task automatic held_pairs();
    logic [0:31] e1;
    logic [0:31] e2;
    logic [0:31] a;
    logic [0:31] b;
    begin_test();
    e1 = make_word(0, $random(seed));
    e2 = make_word(8, $random(seed));
    a  = make_word(4, $random(seed));
    b  = make_word(12, $random(seed));
    // stall lands right after the first half of a split
    present(e1, e2);
    @(posedge clk);
    dependency_stall <= 1'b1;
    @(negedge clk);
    compare_outputs(expected_slot(0, e1), filler(1'b1), 1'b1);
    hold_and_compare(3, expected_slot(0, e1), filler(1'b1), 1'b1);
    @(posedge clk);
    dependency_stall <= 1'b0;
    @(negedge clk);
    wait_for_accept(4);
    // second half issues while a new pair arrives under stall
    @(posedge clk);
    inst_pair        <= {a, b};
    dependency_stall <= 1'b1;
    @(negedge clk);
    compare_outputs(expected_slot(8, e2), filler(1'b1), 1'b1);
    hold_and_compare(3, expected_slot(8, e2), filler(1'b1), 1'b1);
    @(posedge clk);
    dependency_stall <= 1'b0;
    @(negedge clk);
    wait_for_accept(4);
    advance();
    compare_outputs(expected_slot(4, a), expected_slot(12, b), 1'b0);
    report_test("held pairs");
endtask

/* tb_dual_decode.sv */
// dual-issue decode testbench top: clock, reset, DUT, watchdog and test sequence
`include "decode_params.svh"

module tb_dual_decode;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 40;
    localparam int CLK_PERIOD  = 10;

    logic                   clk;
    logic                   reset;
    decode_pkg::inst_pair_t inst_pair;
    logic                   dependency_stall;
    decode_pkg::slot_t      even_slot;
    decode_pkg::slot_t      odd_slot;
    logic                   decode_stall;

    int          seed;
    int          error_count;
    int          errors_at_start;
    int          tests_passed;
    int          tests_failed;
    logic [0:31] nop_word;
    logic [0:31] lnop_word;

    dual_decode i_dut (
        .clk              (clk),
        .reset            (reset),
        .inst_pair        (inst_pair),
        .dependency_stall (dependency_stall),
        .even_slot        (even_slot),
        .odd_slot         (odd_slot),
        .decode_stall     (decode_stall)
    );

    `include "tb_decode_tasks.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ----------------------------------------
    // watchdog
    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        $display("watchdog: tests did not complete within %0d cycles",
                 NUM_TESTS * TEST_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        seed             = 32'h8b41;
        error_count      = 0;
        errors_at_start  = 0;
        tests_passed     = 0;
        tests_failed     = 0;
        nop_word         = {`OP_NOP, 21'b0};
        lnop_word        = {`OP_LNOP, 21'b0};
        clk              = 1'b0;
        reset            = 1'b0;
        dependency_stall = 1'b0;
        // colliding pair during reset, fetch must still see no stall
        inst_pair        = {{`OP_A, 21'b0}, {`OP_SF, 21'b0}};

        reset_values();
        even_formats();
        odd_formats();
        split_pairs();
        nop_pairs();
        held_pairs();

        $display("tests passed: %0d, failed: %0d, mismatches: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
decode_pkg.sv
inst_decoder.sv
issue_router.sv
dual_decode.sv
tb_dual_decode.sv

/* Makefile */
TOP       ?= tb_dual_decode
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/100ps
OBJ_DIR   ?= obj_dir
PASS_TEXT  = Simulation finished: PASS

.PHONY: build run clean

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f vlog.f

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
